//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_snes_mem
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= sim passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build $(TOP) with Verilator, run it, look for the pass message in $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- common/snes_mem_pkg.sv
`default_nettype none

package snes_mem_pkg;

    localparam int ADDR_W  = 23;                // Byte address into shared memory
    localparam int WADDR_W = 22;                // 16-bit word address
    localparam int WRAM_AW = 17;                // 128 KB of WRAM
    localparam int BANK_W  = ADDR_W - WRAM_AW;

    // WRAM sits in the top 128 KB
    localparam logic [BANK_W-1:0] WRAM_BANK_DEF = '1;

    // One memory channel, toggle request plus the access itself
    typedef struct packed {
        logic               req;                // Flips to start an access
        logic [WADDR_W-1:0] addr;
        logic [15:0]        wdata;
        logic [1:0]         ds;                 // Byte lanes, bit 1 is the high byte
        logic               we;
    } mem_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              ce_n;
        logic              word;                // 16-bit fetch
        logic              loading;
    } rom_bus_t;

    typedef struct packed {
        logic [WRAM_AW-1:0] addr;
        logic [7:0]         wdata;
        logic               rd_n;
        logic               wr_n;
    } wram_bus_t;

    // Soft-core side, held until ready
    typedef struct packed {
        logic              valid;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;               // All zero means read
    } rv_req_t;

    typedef struct packed {
        logic              stb;
        logic [ADDR_W-1:0] addr;                // Odd byte address of the pair
        logic [15:0]       data;
    } load_wr_t;

endpackage

`default_nettype wire

//--- rv_bridge/rv_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module rv_bridge (
    input  wire                     mclk,
    input  wire                     resetn,
    input  wire snes_mem_pkg::rv_req_t   rv,
    input  wire                     rv_ack,
    input  wire [15:0]              rv_rdata_w,
    output snes_mem_pkg::mem_req_t  rv_mem,
    output logic                    rv_ready,
    output logic [31:0]             rv_rdata
);
    import snes_mem_pkg::*;

    localparam logic [2:0] RV_IDLE_REQ0  = 3'd0;
    localparam logic [2:0] RV_WAIT0_REQ1 = 3'd1;
    localparam logic [2:0] RV_DATA0      = 3'd2;
    localparam logic [2:0] RV_WAIT1      = 3'd3;
    localparam logic [2:0] RV_DATA1      = 3'd4;

    logic [2:0]  rvst;
    logic        rv_valid_r;
    logic        rv_new_req;    // Request seen while busy
    logic        rv_tgl;
    logic        rv_word;       // Which half is on the bus
    logic [1:0]  rv_ds;
    logic [15:0] rv_dout0;
    logic        write;
    logic        new_req_t;
    logic        ack_eq;

    assign write     = rv.wstrb != 4'b0;
    assign new_req_t = rv.valid && !rv_valid_r;
    assign ack_eq    = rv_tgl == rv_ack;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            rvst       <= RV_IDLE_REQ0;
            rv_valid_r <= 1'b0;
            rv_new_req <= 1'b0;
            rv_tgl     <= 1'b0;
            rv_ready   <= 1'b0;
            rv_word    <= 1'b0;
            rv_ds      <= 2'b11;
        end else begin
            rv_valid_r <= rv.valid;
            rv_ready   <= 1'b0;
            if (new_req_t)
                rv_new_req <= 1'b1;
            case (rvst)
                RV_IDLE_REQ0: if (rv_new_req || new_req_t) begin
                    rv_new_req <= 1'b0;
                    rv_tgl     <= !rv_tgl;
                    if (write && rv.wstrb[1:0] == 2'b00) begin
                        rv_word <= 1'b1;            // High half only
                        rv_ds   <= rv.wstrb[3:2];
                        rvst    <= RV_WAIT1;
                    end else begin
                        rv_word <= 1'b0;
                        rv_ds   <= write ? rv.wstrb[1:0] : 2'b11;
                        rvst    <= RV_WAIT0_REQ1;
                    end
                end
                RV_WAIT0_REQ1: if (ack_eq) begin
                    if (write && rv.wstrb[3:2] == 2'b00) begin
                        rv_ready <= 1'b1;           // Low half was enough
                        rvst     <= RV_IDLE_REQ0;
                    end else begin
                        rv_tgl  <= !rv_tgl;
                        rv_word <= 1'b1;
                        rv_ds   <= write ? rv.wstrb[3:2] : 2'b11;
                        rvst    <= write ? RV_WAIT1 : RV_DATA0;
                    end
                end
                RV_DATA0: rvst <= RV_WAIT1;
                RV_WAIT1: if (ack_eq) begin
                    rv_ready <= 1'b1;
                    rvst     <= write ? RV_IDLE_REQ0 : RV_DATA1;
                end
                RV_DATA1: rvst <= RV_IDLE_REQ0;   // Let the read data settle out
                default:  rvst <= RV_IDLE_REQ0;
            endcase
        end
    end

    // Low word still held by the arbiter here
    always_ff @(posedge mclk) begin
        if (rvst == RV_DATA0)
            rv_dout0 <= rv_rdata_w;
    end

    assign rv_mem = '{
        req:   rv_tgl,
        addr:  {rv.addr[ADDR_W-1:2], rv_word},
        wdata: rv_word ? rv.wdata[31:16] : rv.wdata[15:0],
        ds:    rv_ds,
        we:    write
    };

    assign rv_rdata = {rv_rdata_w, rv_dout0};

endmodule

`default_nettype wire

//--- src/cpu_mem_req.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_mem_req #(
    parameter logic [snes_mem_pkg::BANK_W-1:0] WRAM_BANK = snes_mem_pkg::WRAM_BANK_DEF
) (
    input  wire                     mclk,
    input  wire                     resetn,
    input  wire snes_mem_pkg::rom_bus_t  rom,
    input  wire snes_mem_pkg::wram_bus_t wram,
    input  wire snes_mem_pkg::load_wr_t  load_wr,
    input  wire                     cpu_ack,
    input  wire [15:0]              cpu_rdata,
    output snes_mem_pkg::mem_req_t  cpu_mem,
    output logic                    cpu_busy,
    output logic [15:0]             rom_q,
    output logic [7:0]              wram_q
);
    import snes_mem_pkg::*;

    logic               req_tgl;
    logic [WADDR_W-1:0] req_addr;
    logic [15:0]        req_wdata;
    logic [1:0]         req_ds;
    logic               req_we;
    logic               req_port;       // 0 ROM, 1 WRAM
    logic [ADDR_W-1:0]  rom_addr_sd;
    logic               rom_sd_vld;     // Last ROM address still current
    logic [WRAM_AW-1:0] wram_addr_sd;
    logic               wram_rd_r;
    logic               wram_wr_r;
    logic               busy_r;
    logic [15:0]        port0_q;
    logic [15:0]        port1_q;
    logic [15:0]        port0;
    logic [15:0]        port1;
    logic               wram_rd;
    logic               wram_wr;
    logic               rom_trig;
    logic               wram_trig;
    logic               rd_done;

    assign wram_rd  = !wram.rd_n;
    assign wram_wr  = !wram.wr_n;
    assign rom_trig = !rom.loading && !rom.ce_n && (!rom_sd_vld || rom.addr != rom_addr_sd);
    // New word, or a fresh strobe on the same word
    assign wram_trig = (wram_rd && wram.addr[WRAM_AW-1:1] != wram_addr_sd[WRAM_AW-1:1])
                     || (wram_rd && !wram_rd_r) || (wram_wr && !wram_wr_r);

    assign cpu_busy = req_tgl != cpu_ack;
    assign rd_done  = busy_r && !cpu_busy && !req_we;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            req_tgl    <= 1'b0;
            rom_sd_vld <= 1'b0;
            wram_rd_r  <= 1'b0;
            wram_wr_r  <= 1'b0;
            busy_r     <= 1'b0;
        end else begin
            busy_r    <= cpu_busy;
            wram_rd_r <= wram_rd;
            wram_wr_r <= wram_wr;
            if (rom_trig || load_wr.stb || wram_trig)
                req_tgl <= !req_tgl;
            if (load_wr.stb)
                rom_sd_vld <= 1'b0;     // ROM contents changed
            else if (rom_trig)
                rom_sd_vld <= 1'b1;
        end
    end

    // WRAM is assigned last so it wins a collision
    always_ff @(posedge mclk) begin
        if (load_wr.stb) begin
            req_addr  <= load_wr.addr[ADDR_W-1:1];
            req_wdata <= load_wr.data;
            req_ds    <= 2'b11;
            req_we    <= 1'b1;
            req_port  <= 1'b0;
        end else if (rom_trig) begin
            rom_addr_sd <= rom.addr;
            req_addr    <= rom.addr[ADDR_W-1:1];
            req_ds      <= 2'b11;
            req_we      <= 1'b0;
            req_port    <= 1'b0;
        end
        if (wram_trig) begin
            wram_addr_sd <= wram.addr;
            req_addr     <= {WRAM_BANK, wram.addr[WRAM_AW-1:1]};
            req_wdata    <= {wram.wdata, wram.wdata};
            req_ds       <= {wram.addr[0], !wram.addr[0]};
            req_we       <= wram_wr;
            req_port     <= 1'b1;
        end
        if (rd_done) begin
            if (req_port)
                port1_q <= cpu_rdata;
            else
                port0_q <= cpu_rdata;
        end
    end

    assign cpu_mem = '{req: req_tgl, addr: req_addr, wdata: req_wdata, ds: req_ds, we: req_we};

    // Fresh data shows in the completion cycle
    assign port0 = (rd_done && !req_port) ? cpu_rdata : port0_q;
    assign port1 = (rd_done && req_port) ? cpu_rdata : port1_q;

    assign rom_q  = (rom.word || !rom.addr[0]) ? port0 : {port0[7:0], port0[15:8]};
    assign wram_q = wram.addr[0] ? port1[15:8] : port1[7:0];

endmodule

`default_nettype wire

//--- src/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  wire                     mclk,
    input  wire                     resetn,
    input  wire snes_mem_pkg::mem_req_t  cpu_mem,
    input  wire snes_mem_pkg::mem_req_t  rv_mem,
    input  wire                     mem_ack,
    input  wire [15:0]              mem_rdata,
    output logic                    cpu_ack,
    output logic                    rv_ack,
    output logic [15:0]             cpu_rdata,
    output logic [15:0]             rv_rdata_w,
    output snes_mem_pkg::mem_req_t  mem
);
    import snes_mem_pkg::*;

    logic               busy;
    logic               owner;          // 1 when the soft core holds the port
    logic               mem_tgl;
    logic [WADDR_W-1:0] mem_addr;
    logic [15:0]        mem_wdata;
    logic [1:0]         mem_ds;
    logic               mem_we;
    logic               cpu_pend;
    logic               rv_pend;
    logic               done;
    mem_req_t           grant;

    assign cpu_pend = cpu_mem.req != cpu_ack;
    assign rv_pend  = rv_mem.req != rv_ack;
    assign grant    = cpu_pend ? cpu_mem : rv_mem;  // Console first
    assign done     = busy && mem_ack == mem_tgl;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            busy    <= 1'b0;
            owner   <= 1'b0;
            mem_tgl <= mem_ack;
            cpu_ack <= 1'b0;
            rv_ack  <= 1'b0;
        end else if (!busy) begin
            if (cpu_pend || rv_pend) begin
                busy    <= 1'b1;
                owner   <= !cpu_pend;
                mem_tgl <= !mem_tgl;
            end
        end else if (done) begin
            busy <= 1'b0;
            if (owner)
                rv_ack <= !rv_ack;
            else
                cpu_ack <= !cpu_ack;
        end
    end

    always_ff @(posedge mclk) begin
        if (!busy && (cpu_pend || rv_pend)) begin
            mem_addr  <= grant.addr;
            mem_wdata <= grant.wdata;
            mem_ds    <= grant.ds;
            mem_we    <= grant.we;
        end
        if (done) begin
            if (owner)
                rv_rdata_w <= mem_rdata;
            else
                cpu_rdata <= mem_rdata;
        end
    end

    assign mem = '{req: mem_tgl, addr: mem_addr, wdata: mem_wdata, ds: mem_ds, we: mem_we};

endmodule

`default_nettype wire

//--- src/rom_loader.sv
`timescale 1ns/1ps
`default_nettype none

module rom_loader (
    input  wire                     mclk,
    input  wire                     resetn,
    input  wire                     loading,
    input  wire [7:0]               loader_do,
    input  wire                     loader_do_valid,
    output snes_mem_pkg::load_wr_t  load_wr,
    output logic                    loaded
);
    import snes_mem_pkg::*;

    logic [ADDR_W-1:0] loader_addr;    // Address of the next byte
    logic [7:0]        byte_prev;      // Even byte waiting for its partner
    logic              loading_r;
    logic              wr_stb;
    logic [ADDR_W-1:0] wr_addr;
    logic [15:0]       wr_data;

    always_ff @(posedge mclk) begin
        if (!resetn) begin
            loader_addr <= '0;
            loading_r   <= 1'b0;
            loaded      <= 1'b0;
            wr_stb      <= 1'b0;
        end else begin
            loading_r <= loading;
            wr_stb    <= loader_do_valid && loader_addr[0];   // Pair complete
            if (loader_do_valid)
                loader_addr <= loader_addr + 1'b1;
            // New load restarts from address zero
            if (loading && !loading_r) begin
                loader_addr <= '0;
                loaded      <= 1'b0;
            end
            if (!loading && loading_r)
                loaded <= 1'b1;
        end
    end

    always_ff @(posedge mclk) begin
        if (loader_do_valid) begin
            byte_prev <= loader_do;
            if (loader_addr[0]) begin
                wr_addr <= loader_addr;
                wr_data <= {loader_do, byte_prev};   // Odd byte goes high
            end
        end
    end

    assign load_wr = '{stb: wr_stb, addr: wr_addr, data: wr_data};

endmodule

`default_nettype wire

//--- src/snes_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module snes_mem_top #(
    parameter logic [snes_mem_pkg::BANK_W-1:0] WRAM_BANK = snes_mem_pkg::WRAM_BANK_DEF
) (
    input  wire                     mclk,
    input  wire                     resetn,
    input  wire snes_mem_pkg::rom_bus_t  rom,
    input  wire snes_mem_pkg::wram_bus_t wram,
    input  wire [7:0]               loader_do,
    input  wire                     loader_do_valid,
    input  wire snes_mem_pkg::rv_req_t   rv,
    input  wire                     mem_ack,
    input  wire [15:0]              mem_rdata,
    output logic [15:0]             rom_q,
    output logic [7:0]              wram_q,
    output logic                    cpu_busy,
    output logic                    loaded,
    output logic                    rv_ready,
    output logic [31:0]             rv_rdata,
    output snes_mem_pkg::mem_req_t  mem
);
    import snes_mem_pkg::*;

    load_wr_t    load_wr;
    mem_req_t    cpu_mem;       // Console channel
    mem_req_t    rv_mem;        // Soft-core channel
    logic        cpu_ack;
    logic        rv_ack;
    logic [15:0] cpu_rdata;
    logic [15:0] rv_rdata_w;

    rom_loader i_rom_loader (
        .mclk           (mclk),
        .resetn         (resetn),
        .loading        (rom.loading),
        .loader_do      (loader_do),
        .loader_do_valid(loader_do_valid),
        .load_wr        (load_wr),
        .loaded         (loaded)
    );

    cpu_mem_req #(
        .WRAM_BANK(WRAM_BANK)
    ) i_cpu_mem_req (
        .mclk     (mclk),
        .resetn   (resetn),
        .rom      (rom),
        .wram     (wram),
        .load_wr  (load_wr),
        .cpu_ack  (cpu_ack),
        .cpu_rdata(cpu_rdata),
        .cpu_mem  (cpu_mem),
        .cpu_busy (cpu_busy),
        .rom_q    (rom_q),
        .wram_q   (wram_q)
    );

    rv_bridge i_rv_bridge (
        .mclk      (mclk),
        .resetn    (resetn),
        .rv        (rv),
        .rv_ack    (rv_ack),
        .rv_rdata_w(rv_rdata_w),
        .rv_mem    (rv_mem),
        .rv_ready  (rv_ready),
        .rv_rdata  (rv_rdata)
    );

    mem_arbiter i_mem_arbiter (
        .mclk      (mclk),
        .resetn    (resetn),
        .cpu_mem   (cpu_mem),
        .rv_mem    (rv_mem),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .cpu_ack   (cpu_ack),
        .rv_ack    (rv_ack),
        .cpu_rdata (cpu_rdata),
        .rv_rdata_w(rv_rdata_w),
        .mem       (mem)
    );

endmodule

`default_nettype wire

//--- test/tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_model (
    input  wire                          mclk,
    input  wire                          resetn,
    input  wire snes_mem_pkg::mem_req_t  mem,
    output logic                         mem_ack,
    output logic [15:0]                  mem_rdata
);
    import snes_mem_pkg::*;

    logic [15:0] mem_words [logic [WADDR_W-1:0]];   // Only words that were written
    logic [15:0] cur;
    logic        active;
    int          delay;

    // Untouched words read back a pattern of their own address
    function automatic logic [15:0] fill_word(input logic [WADDR_W-1:0] w);
        return w[15:0] ^ {w[5:0], w[21:12]};
    endfunction

    always @(posedge mclk) begin
        if (!resetn) begin
            mem_ack   <= 1'b0;
            mem_rdata <= '0;
            active    <= 1'b0;
            delay     <= 0;
        end else if (!active) begin
            if (mem.req != mem_ack) begin
                active <= 1'b1;
                delay  <= $urandom_range(6, 1);     // Random latency
            end
        end else if (delay > 1) begin
            delay <= delay - 1;
        end else begin
            if (mem_words.exists(mem.addr))
                cur = mem_words[mem.addr];
            else
                cur = fill_word(mem.addr);
            if (mem.we) begin
                if (mem.ds[1])
                    cur[15:8] = mem.wdata[15:8];
                if (mem.ds[0])
                    cur[7:0] = mem.wdata[7:0];
                mem_words[mem.addr] = cur;
            end
            mem_rdata <= cur;
            mem_ack   <= mem.req;                   // Completes the toggle
            active    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- test/tb_snes_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_snes_mem;
    import snes_mem_pkg::*;

    localparam logic [BANK_W-1:0] BANK    = WRAM_BANK_DEF;
    localparam logic [ADDR_W-1:0] RV_BASE = 23'h040000;
    localparam int LOAD_BYTES = 64;
    localparam int TIMEOUT    = 64;

    logic        mclk;
    logic        resetn;
    rom_bus_t    rom;
    wram_bus_t   wram;
    logic [7:0]  loader_do;
    logic        loader_do_valid;
    rv_req_t     rv;
    logic        mem_ack;
    logic [15:0] mem_rdata;
    logic [15:0] rom_q;
    logic [7:0]  wram_q;
    logic        cpu_busy;
    logic        loaded;
    logic        rv_ready;
    logic [31:0] rv_rdata;
    mem_req_t    mem;

    logic [7:0]         ref_mem [logic [ADDR_W-1:0]];   // Expected bytes by byte address
    logic [WRAM_AW-1:0] wram_written[$];

    snes_mem_top #(
        .WRAM_BANK(BANK)
    ) i_snes_mem_top (
        .mclk           (mclk),
        .resetn         (resetn),
        .rom            (rom),
        .wram           (wram),
        .loader_do      (loader_do),
        .loader_do_valid(loader_do_valid),
        .rv             (rv),
        .mem_ack        (mem_ack),
        .mem_rdata      (mem_rdata),
        .rom_q          (rom_q),
        .wram_q         (wram_q),
        .cpu_busy       (cpu_busy),
        .loaded         (loaded),
        .rv_ready       (rv_ready),
        .rv_rdata       (rv_rdata),
        .mem            (mem)
    );

    tb_mem_model i_mem_model (
        .mclk     (mclk),
        .resetn   (resetn),
        .mem      (mem),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata)
    );

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;
    end

    // Same pattern the memory model starts with
    function automatic logic [15:0] fill_word(input logic [WADDR_W-1:0] w);
        return w[15:0] ^ {w[5:0], w[21:12]};
    endfunction

    function automatic logic [7:0] expect_byte(input logic [ADDR_W-1:0] a);
        logic [15:0] w;
        w = fill_word(a[ADDR_W-1:1]);
        if (ref_mem.exists(a))
            return ref_mem[a];
        else
            return a[0] ? w[15:8] : w[7:0];
    endfunction

    function automatic logic [31:0] expect_word(input logic [ADDR_W-1:0] a);
        return {expect_byte({a[ADDR_W-1:2], 2'd3}), expect_byte({a[ADDR_W-1:2], 2'd2}),
                expect_byte({a[ADDR_W-1:2], 2'd1}), expect_byte({a[ADDR_W-1:2], 2'd0})};
    endfunction

    task automatic abort_run();
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: %s is %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Busy has to rise first, then fall
    task automatic wait_console(input string what);
        int n;
        n = 0;
        while (!cpu_busy && n < 8) begin
            @(negedge mclk);
            n++;
        end
        if (!cpu_busy) begin
            $display("Timeout: %s never made the console busy", what);
            abort_run();
        end else begin
            n = 0;
            while (cpu_busy && n < TIMEOUT) begin
                @(negedge mclk);
                n++;
            end
            if (cpu_busy) begin
                $display("Timeout: %s never finished", what);
                abort_run();
            end
        end
    endtask

    task automatic wait_rv(input string what);
        int n;
        n = 0;
        while (!rv_ready && n < TIMEOUT) begin
            @(negedge mclk);
            n++;
        end
        if (!rv_ready) begin
            $display("Timeout: no ready pulse for %s", what);
            abort_run();
        end
    endtask

    task automatic load_rom();
        int i;
        int n;
        logic [7:0] b;
        @(negedge mclk);
        rom.loading = 1'b1;
        @(negedge mclk);                    // Loader address restarts here
        for (i = 0; i < LOAD_BYTES; i++) begin
            b = 8'($urandom);
            loader_do       = b;
            loader_do_valid = 1'b1;
            ref_mem[23'(i)] = b;
            @(negedge mclk);
            if (i % 2 == 1) begin
                loader_do_valid = 1'b0;
                wait_console("ROM load write");
            end
        end
        rom.loading = 1'b0;
        n = 0;
        while (!loaded && n < 8) begin
            @(negedge mclk);
            n++;
        end
        if (!loaded) begin
            $display("Timeout: loaded never rose after the load ended");
            abort_run();
        end else begin
            for (i = 0; i < LOAD_BYTES / 2; i++)
                check("model ROM word", 32'(i_mem_model.mem_words[22'(i)]),
                      {16'd0, ref_mem[23'(2 * i + 1)], ref_mem[23'(2 * i)]});
        end
    endtask

    task automatic read_rom(input logic [ADDR_W-1:0] a, input logic word);
        logic [15:0] w;
        @(negedge mclk);
        rom.addr = a;
        rom.word = word;
        rom.ce_n = 1'b0;
        wait_console("ROM read");
        w = {expect_byte({a[ADDR_W-1:1], 1'b1}), expect_byte({a[ADDR_W-1:1], 1'b0})};
        if (!word && a[0])
            w = {w[7:0], w[15:8]};          // Odd byte fetch comes back swapped
        check("rom_q", 32'(rom_q), 32'(w));
    endtask

    task automatic write_wram(input logic [WRAM_AW-1:0] a, input logic [7:0] d);
        @(negedge mclk);
        wram.addr  = a;
        wram.wdata = d;
        wram.wr_n  = 1'b0;
        ref_mem[{BANK, a}] = d;
        wait_console("WRAM write");
        wram.wr_n = 1'b1;
    endtask

    task automatic read_wram(input logic [WRAM_AW-1:0] a);
        @(negedge mclk);
        wram.addr = a;
        wram.rd_n = 1'b0;
        wait_console("WRAM read");
        check("wram_q", 32'(wram_q), 32'(expect_byte({BANK, a})));
        wram.rd_n = 1'b1;
    endtask

    task automatic rv_access(input logic [ADDR_W-1:0] a, input logic [31:0] d,
                             input logic [3:0] strb);
        int k;
        @(negedge mclk);
        rv = '{valid: 1'b1, addr: a, wdata: d, wstrb: strb};
        for (k = 0; k < 4; k++) begin
            if (strb[k])
                ref_mem[{a[ADDR_W-1:2], 2'(k)}] = d[8 * k +: 8];
        end
        wait_rv("soft-core access");
        if (strb == 4'b0000)
            check("rv_rdata", rv_rdata, expect_word(a));
        rv.valid = 1'b0;
    endtask

    // Console and soft core start in the same cycle
    task automatic run_together(input logic write, input logic [WRAM_AW-1:0] wa,
                                input logic [ADDR_W-1:0] ra);
        int n;
        int k;
        logic cpu_seen;
        logic cpu_done;
        logic rv_done;
        logic [31:0] rv_got;
        logic [31:0] d;
        logic [3:0] strb;
        n        = 0;
        cpu_seen = 1'b0;
        cpu_done = 1'b0;
        rv_done  = 1'b0;
        rv_got   = '0;
        d        = $urandom;
        strb     = write ? 4'($urandom_range(15, 1)) : 4'b0000;
        @(negedge mclk);
        wram.addr  = wa;
        wram.wdata = d[7:0];
        if (write) begin
            wram.wr_n = 1'b0;
            ref_mem[{BANK, wa}] = d[7:0];
        end else begin
            wram.rd_n = 1'b0;
        end
        rv = '{valid: 1'b1, addr: ra, wdata: d, wstrb: strb};
        for (k = 0; k < 4; k++) begin
            if (strb[k])
                ref_mem[{ra[ADDR_W-1:2], 2'(k)}] = d[8 * k +: 8];
        end
        while (!(cpu_done && rv_done) && n < TIMEOUT) begin
            @(negedge mclk);
            n++;
            if (cpu_busy)
                cpu_seen = 1'b1;
            else if (cpu_seen)
                cpu_done = 1'b1;
            if (rv_ready) begin
                rv_done = 1'b1;
                rv_got  = rv_rdata;
            end
        end
        if (!(cpu_done && rv_done)) begin
            $display("Timeout: concurrent console and soft-core access did not finish");
            abort_run();
        end else begin
            if (!write) begin
                check("wram_q", 32'(wram_q), 32'(expect_byte({BANK, wa})));
                check("rv_rdata", rv_got, expect_word(ra));
            end
            wram.wr_n = 1'b1;
            wram.rd_n = 1'b1;
            rv.valid  = 1'b0;
        end
    endtask

    initial begin
        int unsigned seed;
        int i;
        logic [ADDR_W-1:0] a;
        logic [WRAM_AW-1:0] wa;
        logic [3:0] strb;
        seed            = $urandom(32'h6b5e);
        resetn          = 1'b0;
        rom             = '{addr: '0, ce_n: 1'b1, word: 1'b0, loading: 1'b0};
        wram            = '{addr: '0, wdata: '0, rd_n: 1'b1, wr_n: 1'b1};
        loader_do       = '0;
        loader_do_valid = 1'b0;
        rv              = '0;
        repeat (3) @(negedge mclk);
        resetn = 1'b1;
        @(negedge mclk);

        check("cpu_busy", 32'(cpu_busy), 32'd0);
        check("rv_ready", 32'(rv_ready), 32'd0);
        check("loaded", 32'(loaded), 32'd0);
        check("mem.req", 32'(mem.req), 32'(mem_ack));

        load_rom();

        for (i = 0; i < 24; i++) begin
            do
                a = 23'($urandom_range(LOAD_BYTES - 1, 0));
            while (a == rom.addr);          // Same address would not retrigger
            read_rom(a, 1'($urandom));
        end
        rom.ce_n = 1'b1;

        // WRAM in a 32-byte window so words get both halves hit
        for (i = 0; i < 20; i++) begin
            wa = {12'hfff, 5'($urandom)};
            write_wram(wa, 8'($urandom));
            wram_written.push_back(wa);
        end
        for (i = 0; i < wram_written.size(); i++) begin
            wa = wram_written[i];
            check("model WRAM word",
                  32'(i_mem_model.mem_words[{BANK, wa[WRAM_AW-1:1]}]),
                  {16'd0, expect_byte({BANK, wa[WRAM_AW-1:1], 1'b1}),
                   expect_byte({BANK, wa[WRAM_AW-1:1], 1'b0})});
        end
        for (i = 0; i < 24; i++)
            read_wram({12'hfff, 5'($urandom)});

        for (i = 0; i < 24; i++) begin
            a = RV_BASE + {18'd0, 3'($urandom_range(7, 0)), 2'b00};
            case (i % 4)
                0:       strb = {2'b00, 2'($urandom_range(3, 1))};   // Low half only
                1:       strb = {2'($urandom_range(3, 1)), 2'b00};   // High half only
                default: strb = 4'($urandom_range(15, 1));
            endcase
            rv_access(a, $urandom, strb);
        end
        for (i = 0; i < 8; i++)
            rv_access(RV_BASE + 23'(4 * i), 32'd0, 4'b0000);

        for (i = 0; i < 6; i++) begin
            wa = {12'hfff, 5'($urandom)};
            a  = RV_BASE + {18'd0, 3'($urandom_range(7, 0)), 2'b00};
            run_together(1'b1, wa, a);
            run_together(1'b0, wa, a);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
common/snes_mem_pkg.sv
src/rom_loader.sv
src/cpu_mem_req.sv
rv_bridge/rv_bridge.sv
src/mem_arbiter.sv
src/snes_mem_top.sv
test/tb_mem_model.sv
test/tb_snes_mem.sv
